//--- src/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// data and address width
`define XLEN 32

// instruction word width, same as the datapath on rv32
`define ILEN 32

// global history tag carried with each prediction
`define HISLEN 8

// register index width
`define REG_ADDRWIDTH 5

// trap bus width
`define TRAP_LEN 4

// bit 0 of the trap bus flags ebreak, the rest pass through
`define TRAP_EBREAK_BIT 0

// branch statistics counter width
`define STAT_CNT_LEN 32

// link offset for jal/jalr and fallthrough pc
`define PC_STEP 4

// immediate bits cleared for lui/auipc
`define UIMM_LSB 12

// shift amount width taken from operand b
`define SHAMT_LEN 5

`endif

//--- src/exu_pkg.sv
`include "exu_defines.svh"

package exu_pkg;

  // instruction class from decode
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_LUI    = 4'd1,
    EXC_AUIPC  = 4'd2,
    EXC_JAL    = 4'd3,
    EXC_JALR   = 4'd4,
    EXC_LOAD   = 4'd5,
    EXC_STORE  = 4'd6,
    EXC_BRANCH = 4'd7,
    EXC_OPIMM  = 4'd8,
    EXC_OPREG  = 4'd9,
    EXC_EBREAK = 4'd10
  } exc_op_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND,
    // compare codes for branches
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // only carried through to mem
  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
  } mem_op_e;

  typedef enum logic [1:0] {
    JT_NONE   = 2'b00,
    JT_JAL    = 2'b01,
    JT_JALR   = 2'b10,
    JT_BRANCH = 2'b11
  } jump_type_e;

  typedef struct packed {
    logic               taken;    // predicted direction
    logic               sel;      // which predictor gave it
    logic [`HISLEN-1:0] history;
  } pdt_t;

  typedef struct packed {
    logic                      valid;
    logic [`XLEN-1:0]          pc;
    logic [`ILEN-1:0]          inst;
    logic [`REG_ADDRWIDTH-1:0] rd;
    logic [`XLEN-1:0]          rs1;
    logic [`XLEN-1:0]          rs2;
    logic [`XLEN-1:0]          imm;
    exc_op_e                   exc_op;
    alu_op_e                   alu_op;
    mem_op_e                   mem_op;
    logic [`TRAP_LEN-1:0]      trap;
    pdt_t                      pdt;
  } id_ex_t;

  typedef struct packed {
    logic                      valid;
    logic [`XLEN-1:0]          pc;
    logic [`ILEN-1:0]          inst;
    logic [`REG_ADDRWIDTH-1:0] rd;
    logic [`XLEN-1:0]          result;
    logic [`XLEN-1:0]          store_data;  // rs2 for stores
    mem_op_e                   mem_op;
    logic [`TRAP_LEN-1:0]      trap;
  } ex_mem_t;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    logic               taken;
    logic               correct;
    jump_type_e         jump_type;
    logic               sel;
    logic [`HISLEN-1:0] history;
  } bpu_upd_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] target;
  } redirect_t;

endpackage

//--- src/alu.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module alu (
  input  logic [`XLEN-1:0] alu_a_i,
  input  logic [`XLEN-1:0] alu_b_i,
  input  exu_pkg::alu_op_e alu_op_i,
  output logic [`XLEN-1:0] alu_out_o,
  output logic             compare_out_o
);
  import exu_pkg::*;

  logic [`SHAMT_LEN-1:0] shamt;
  logic [`XLEN-1:0]      sum;
  logic [`XLEN-1:0]      diff;
  logic                  lt_s;
  logic                  lt_u;
  logic                  eq;

  assign shamt = alu_b_i[`SHAMT_LEN-1:0];  // rv32 uses low 5 bits only
  assign sum   = alu_a_i + alu_b_i;
  assign diff  = alu_a_i - alu_b_i;

  // shared relations for slt and the branch compares
  assign lt_s = $signed(alu_a_i) < $signed(alu_b_i);
  assign lt_u = alu_a_i < alu_b_i;
  assign eq   = alu_a_i == alu_b_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_out_o = sum;
      ALU_SUB:  alu_out_o = diff;
      ALU_SLL:  alu_out_o = alu_a_i << shamt;
      ALU_SLT:  alu_out_o = {{(`XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: alu_out_o = {{(`XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  alu_out_o = alu_a_i ^ alu_b_i;
      ALU_SRL:  alu_out_o = alu_a_i >> shamt;
      ALU_SRA:  alu_out_o = $unsigned($signed(alu_a_i) >>> shamt);
      ALU_OR:   alu_out_o = alu_a_i | alu_b_i;
      ALU_AND:  alu_out_o = alu_a_i & alu_b_i;
      // compare codes put the difference on the data output
      default:  alu_out_o = diff;
    endcase
  end

  always_comb begin
    case (alu_op_i)
      ALU_EQ:  compare_out_o = eq;
      ALU_NE:  compare_out_o = ~eq;
      ALU_LT:  compare_out_o = lt_s;
      ALU_GE:  compare_out_o = ~lt_s;
      ALU_LTU: compare_out_o = lt_u;
      ALU_GEU: compare_out_o = ~lt_u;
      default: compare_out_o = 1'b0;  // not a branch compare
    endcase
  end

endmodule

//--- src/branch_resolve.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module branch_resolve (
  input  exu_pkg::exc_op_e    exc_op_i,
  input  logic [`XLEN-1:0]    pc_i,
  input  logic [`XLEN-1:0]    rs1_i,
  input  logic [`XLEN-1:0]    imm_i,
  input  logic                compare_i,
  input  logic                pdt_taken_i,
  output logic                taken_o,
  output logic                is_jump_o,
  output exu_pkg::jump_type_e jump_type_o,
  output logic                mispredict_o,
  output logic [`XLEN-1:0]    target_o
);
  import exu_pkg::*;

  logic             is_branch;
  logic             is_jal;
  logic             is_jalr;
  logic [`XLEN-1:0] tgt_base;
  logic [`XLEN-1:0] tgt_offs;

  assign is_branch = exc_op_i == EXC_BRANCH;
  assign is_jal    = exc_op_i == EXC_JAL;
  assign is_jalr   = exc_op_i == EXC_JALR;

  // jumps are always taken, branches follow the compare
  assign taken_o   = (is_branch & compare_i) | is_jal | is_jalr;
  assign is_jump_o = is_branch | is_jal | is_jalr;

  always_comb begin
    if (is_jal)
      jump_type_o = JT_JAL;
    else if (is_jalr)
      jump_type_o = JT_JALR;
    else if (is_branch)
      jump_type_o = JT_BRANCH;
    else
      jump_type_o = JT_NONE;
  end

  assign mispredict_o = taken_o != pdt_taken_i;

  // one adder for both the fallthrough and the jump target
  always_comb begin
    if (pdt_taken_i && !taken_o) begin
      tgt_base = pc_i;  // wrongly predicted taken, back to pc+4
      tgt_offs = `XLEN'(`PC_STEP);
    end else begin
      tgt_base = is_jalr ? rs1_i : pc_i;
      tgt_offs = imm_i;
    end
  end

  assign target_o = tgt_base + tgt_offs;

endmodule

//--- src/exu.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu (
  input  exu_pkg::id_ex_t    id_ex_i,
  input  logic               stall_i,
  output logic               advance_o,
  output exu_pkg::ex_mem_t   result_o,
  output logic [`XLEN-1:0]   alu_fwd_o,
  output exu_pkg::redirect_t redirect_o,
  output exu_pkg::bpu_upd_t  bpu_upd_o
);
  import exu_pkg::*;

  logic [`XLEN-1:0]     alu_a;
  logic [`XLEN-1:0]     alu_b;
  logic [`XLEN-1:0]     alu_out;
  logic [`XLEN-1:0]     imm_upper;
  logic [`XLEN-1:0]     br_target;
  logic                 compare;
  logic                 taken;
  logic                 is_jump;
  logic                 mispredict;
  logic                 is_ebreak;
  logic [`TRAP_LEN-1:0] ebreak_bit;
  jump_type_e           jump_type;

  // stage moves on only with a real instruction and no memory stall
  assign advance_o = id_ex_i.valid & ~stall_i;

  assign imm_upper = {id_ex_i.imm[`XLEN-1:`UIMM_LSB], {`UIMM_LSB{1'b0}}};

  always_comb begin
    case (id_ex_i.exc_op)
      EXC_OPREG, EXC_BRANCH: begin
        alu_a = id_ex_i.rs1;
        alu_b = id_ex_i.rs2;
      end
      EXC_OPIMM, EXC_LOAD, EXC_STORE: begin
        alu_a = id_ex_i.rs1;
        alu_b = id_ex_i.imm;  // address or immediate op
      end
      EXC_JAL, EXC_JALR: begin
        alu_a = id_ex_i.pc;
        alu_b = `XLEN'(`PC_STEP);  // link value
      end
      EXC_AUIPC: begin
        alu_a = id_ex_i.pc;
        alu_b = imm_upper;
      end
      EXC_LUI: begin
        alu_a = '0;
        alu_b = imm_upper;
      end
      default: begin
        alu_a = '0;
        alu_b = '0;
      end
    endcase
  end

  alu u_alu (
    .alu_a_i       (alu_a),
    .alu_b_i       (alu_b),
    .alu_op_i      (id_ex_i.alu_op),
    .alu_out_o     (alu_out),
    .compare_out_o (compare)
  );

  branch_resolve u_branch_resolve (
    .exc_op_i     (id_ex_i.exc_op),
    .pc_i         (id_ex_i.pc),
    .rs1_i        (id_ex_i.rs1),
    .imm_i        (id_ex_i.imm),
    .compare_i    (compare),
    .pdt_taken_i  (id_ex_i.pdt.taken),
    .taken_o      (taken),
    .is_jump_o    (is_jump),
    .jump_type_o  (jump_type),
    .mispredict_o (mispredict),
    .target_o     (br_target)
  );

  assign alu_fwd_o = alu_out;  // back to id for forwarding

  assign is_ebreak  = id_ex_i.exc_op == EXC_EBREAK;
  assign ebreak_bit = `TRAP_LEN'(is_ebreak) << `TRAP_EBREAK_BIT;

  always_comb begin
    result_o.valid      = id_ex_i.valid;
    result_o.pc         = id_ex_i.pc;
    result_o.inst       = id_ex_i.inst;
    result_o.rd         = id_ex_i.rd;
    result_o.result     = alu_out;
    result_o.store_data = id_ex_i.rs2;
    result_o.mem_op     = id_ex_i.mem_op;
    result_o.trap       = id_ex_i.trap | ebreak_bit;  // upper trap bits untouched
  end

  // single cycle strobes, only for the accepted instruction
  assign redirect_o.valid  = advance_o & mispredict;
  assign redirect_o.target = br_target;

  always_comb begin
    bpu_upd_o.valid     = advance_o & is_jump;
    bpu_upd_o.pc        = id_ex_i.pc;
    bpu_upd_o.taken     = taken;
    bpu_upd_o.correct   = ~mispredict;
    bpu_upd_o.jump_type = jump_type;
    bpu_upd_o.sel       = id_ex_i.pdt.sel;
    bpu_upd_o.history   = id_ex_i.pdt.history;
  end

endmodule

//--- src/ex_mem_reg.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module ex_mem_reg (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             load_i,
  input  exu_pkg::ex_mem_t data_i,
  output exu_pkg::ex_mem_t data_o
);
  import exu_pkg::*;

  ex_mem_t data_q;

  // payload only moves on load, a bubble just drops valid
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      data_q <= data_i;
    end else begin
      data_q.valid <= 1'b0;
    end
    if (rst_i) begin
      data_q.valid <= 1'b0;  // control bit only
    end
  end

  assign data_o = data_q;

endmodule

//--- src/bpu_stats.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module bpu_stats (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  exu_pkg::bpu_upd_t        upd_i,
  output logic [`STAT_CNT_LEN-1:0] branch_cnt_o,
  output logic [`STAT_CNT_LEN-1:0] mispredict_cnt_o
);
  import exu_pkg::*;

  logic count_branch;
  logic count_miss;

  assign count_branch = upd_i.valid;
  assign count_miss   = upd_i.valid & ~upd_i.correct;

  // readable from a debug register, wraps on overflow
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      branch_cnt_o     <= '0;
      mispredict_cnt_o <= '0;
    end else begin
      if (count_branch)
        branch_cnt_o <= branch_cnt_o + 1'b1;
      if (count_miss)
        mispredict_cnt_o <= mispredict_cnt_o + 1'b1;  // wrong direction
    end
  end

endmodule

//--- src/exu_top.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_top (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  exu_pkg::id_ex_t          id_ex_i,
  input  logic                     ram_stall_i,
  output exu_pkg::ex_mem_t         ex_mem_o,
  output exu_pkg::redirect_t       redirect_o,
  output exu_pkg::bpu_upd_t        bpu_upd_o,
  output logic [`XLEN-1:0]         alu_fwd_o,
  output logic [`STAT_CNT_LEN-1:0] branch_cnt_o,
  output logic [`STAT_CNT_LEN-1:0] mispredict_cnt_o
);
  import exu_pkg::*;

  logic    advance;
  ex_mem_t ex_result;

  exu u_exu (
    .id_ex_i    (id_ex_i),
    .stall_i    (ram_stall_i),
    .advance_o  (advance),
    .result_o   (ex_result),
    .alu_fwd_o  (alu_fwd_o),
    .redirect_o (redirect_o),
    .bpu_upd_o  (bpu_upd_o)
  );

  // result lands in ex/mem one cycle later
  ex_mem_reg u_ex_mem_reg (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .load_i (advance),
    .data_i (ex_result),
    .data_o (ex_mem_o)
  );

  // counts every predictor update leaving the stage
  bpu_stats u_bpu_stats (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .upd_i            (bpu_upd_o),
    .branch_cnt_o     (branch_cnt_o),
    .mispredict_cnt_o (mispredict_cnt_o)
  );

endmodule

//--- verif/exu_tb.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_tb;
  import exu_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int DRAIN_LIMIT  = 8;
  localparam int STALL_LIMIT  = 16;
  localparam int WATCHDOG_CYC = 2000;

  logic                     clk_i;
  logic                     rst_i;
  id_ex_t                   id_ex_i;
  logic                     ram_stall_i;
  ex_mem_t                  ex_mem_o;
  redirect_t                redirect_o;
  bpu_upd_t                 bpu_upd_o;
  logic [`XLEN-1:0]         alu_fwd_o;
  logic [`STAT_CNT_LEN-1:0] branch_cnt_o;
  logic [`STAT_CNT_LEN-1:0] mispredict_cnt_o;

  int          value_errors;
  int          timeout_errors;
  logic [31:0] lfsr_state;
  ex_mem_t     exp_prev;      // model of the ex/mem latch
  int          exp_branches;
  int          exp_misses;

  exc_op_e alu_classes [4]  = '{EXC_OPREG, EXC_OPIMM, EXC_LUI, EXC_AUIPC};
  exc_op_e jump_classes [4] = '{EXC_BRANCH, EXC_BRANCH, EXC_JAL, EXC_JALR};
  exc_op_e mix_classes [10] = '{EXC_OPREG, EXC_OPIMM, EXC_LUI, EXC_AUIPC, EXC_BRANCH,
                                EXC_JAL, EXC_JALR, EXC_LOAD, EXC_STORE, EXC_EBREAK};

  exu_top uut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .id_ex_i          (id_ex_i),
    .ram_stall_i      (ram_stall_i),
    .ex_mem_o         (ex_mem_o),
    .redirect_o       (redirect_o),
    .bpu_upd_o        (bpu_upd_o),
    .alu_fwd_o        (alu_fwd_o),
    .branch_cnt_o     (branch_cnt_o),
    .mispredict_cnt_o (mispredict_cnt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return a - b;  // compare codes
    endcase
  endfunction

  function automatic logic cond_holds(input alu_op_e op, input logic [31:0] a,
                                      input logic [31:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] expected_fwd(input id_ex_t ins);
    logic [31:0] upper;
    upper = ins.imm & 32'hffff_f000;
    case (ins.exc_op)
      EXC_OPREG, EXC_BRANCH:          return alu_model(ins.alu_op, ins.rs1, ins.rs2);
      EXC_OPIMM, EXC_LOAD, EXC_STORE: return alu_model(ins.alu_op, ins.rs1, ins.imm);
      EXC_JAL, EXC_JALR:              return alu_model(ins.alu_op, ins.pc, 32'd4);
      EXC_AUIPC:                      return alu_model(ins.alu_op, ins.pc, upper);
      EXC_LUI:                        return alu_model(ins.alu_op, 32'd0, upper);
      default:                        return alu_model(ins.alu_op, 32'd0, 32'd0);
    endcase
  endfunction

  function automatic id_ex_t make_instr(input exc_op_e cls);
    id_ex_t ins;
    ins.valid       = 1'b1;
    ins.pc          = rand_bits(30) << 2;
    ins.inst        = rand_bits(32);
    ins.rd          = 5'(rand_bits(5));
    ins.rs1         = rand_bits(32);
    ins.rs2         = (rand_bits(2) == 0) ? ins.rs1 : rand_bits(32);  // equal now and then
    ins.imm         = rand_bits(32);
    ins.exc_op      = cls;
    ins.mem_op      = mem_op_e'(4'(rand_bits(4) % 9));
    ins.trap        = `TRAP_LEN'(rand_bits(`TRAP_LEN)) & 4'b1110;
    ins.pdt.taken   = 1'(rand_bits(1));
    ins.pdt.sel     = 1'(rand_bits(1));
    ins.pdt.history = `HISLEN'(rand_bits(`HISLEN));
    case (cls)
      EXC_OPREG, EXC_OPIMM: ins.alu_op = alu_op_e'(5'(rand_bits(4) % 10));
      EXC_BRANCH:           ins.alu_op = alu_op_e'(5'(ALU_EQ) + 5'(rand_bits(3) % 6));
      default:              ins.alu_op = ALU_ADD;
    endcase
    return ins;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
        value_errors++;
      end
  endtask

  // drives on the rising edge, checks at the falling edge and then steps the model
  task automatic run_cycle(input id_ex_t ins, input logic stall);
    logic        adv;
    logic        is_jump;
    logic        taken;
    logic        miss;
    logic [31:0] res;
    logic [31:0] target;
    jump_type_e  jt;
    @(posedge clk_i);
    id_ex_i     <= ins;
    ram_stall_i <= stall;
    @(negedge clk_i);
    check_val("ex_mem_o.valid", 32'(exp_prev.valid), 32'(ex_mem_o.valid));
    if (exp_prev.valid) begin
      check_val("ex_mem_o.pc", exp_prev.pc, ex_mem_o.pc);
      check_val("ex_mem_o.inst", exp_prev.inst, ex_mem_o.inst);
      check_val("ex_mem_o.rd", 32'(exp_prev.rd), 32'(ex_mem_o.rd));
      check_val("ex_mem_o.result", exp_prev.result, ex_mem_o.result);
      check_val("ex_mem_o.store_data", exp_prev.store_data, ex_mem_o.store_data);
      check_val("ex_mem_o.mem_op", 32'(exp_prev.mem_op), 32'(ex_mem_o.mem_op));
      check_val("ex_mem_o.trap", 32'(exp_prev.trap), 32'(ex_mem_o.trap));
    end
    check_val("branch_cnt_o", 32'(exp_branches), branch_cnt_o);
    check_val("mispredict_cnt_o", 32'(exp_misses), mispredict_cnt_o);

    adv     = ins.valid && !stall;
    res     = expected_fwd(ins);
    is_jump = ins.exc_op inside {EXC_BRANCH, EXC_JAL, EXC_JALR};
    taken   = (ins.exc_op == EXC_BRANCH) ? cond_holds(ins.alu_op, ins.rs1, ins.rs2)
                                         : (ins.exc_op inside {EXC_JAL, EXC_JALR});
    miss    = taken != ins.pdt.taken;
    if (ins.pdt.taken && !taken)
      target = ins.pc + 32'd4;  // fall through
    else if (ins.exc_op == EXC_JALR)
      target = ins.rs1 + ins.imm;
    else
      target = ins.pc + ins.imm;
    case (ins.exc_op)
      EXC_JAL:    jt = JT_JAL;
      EXC_JALR:   jt = JT_JALR;
      EXC_BRANCH: jt = JT_BRANCH;
      default:    jt = JT_NONE;
    endcase

    check_val("alu_fwd_o", res, alu_fwd_o);
    check_val("redirect_o.valid", 32'(adv && miss), 32'(redirect_o.valid));
    check_val("bpu_upd_o.valid", 32'(adv && is_jump), 32'(bpu_upd_o.valid));
    if (adv && (is_jump || miss))
      check_val("redirect_o.target", target, redirect_o.target);
    if (adv && is_jump) begin
      check_val("bpu_upd_o.taken", 32'(taken), 32'(bpu_upd_o.taken));
      check_val("bpu_upd_o.correct", 32'(!miss), 32'(bpu_upd_o.correct));
      check_val("bpu_upd_o.jump_type", 32'(jt), 32'(bpu_upd_o.jump_type));
      check_val("bpu_upd_o.pc", ins.pc, bpu_upd_o.pc);
      check_val("bpu_upd_o.sel", 32'(ins.pdt.sel), 32'(bpu_upd_o.sel));
      check_val("bpu_upd_o.history", 32'(ins.pdt.history), 32'(bpu_upd_o.history));
    end

    exp_prev.valid = adv;  // payload of a bubble is not checked
    if (adv) begin
      exp_prev.pc         = ins.pc;
      exp_prev.inst       = ins.inst;
      exp_prev.rd         = ins.rd;
      exp_prev.result     = res;
      exp_prev.store_data = ins.rs2;
      exp_prev.mem_op     = ins.mem_op;
      exp_prev.trap       = ins.trap | ((ins.exc_op == EXC_EBREAK) ? 4'b0001 : 4'b0000);
    end
    if (adv && is_jump) begin
      exp_branches++;
      if (miss)
        exp_misses++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      run_cycle('0, 1'b0);
      n++;
    end while (ex_mem_o.valid && n < DRAIN_LIMIT);
    if (ex_mem_o.valid) begin
      $display("timeout: EX/MEM latch still valid after %0d idle cycles", n);
      timeout_errors++;
    end
  endtask

  // a stalled instruction emits no strobe and leaves a bubble behind
  stall_no_strobe: assert property (@(negedge clk_i) disable iff (rst_i)
      ram_stall_i |-> !(redirect_o.valid || bpu_upd_o.valid))
    else begin
      $display("CHECK FAILED t=%0t redirect_o.valid|bpu_upd_o.valid expected 0 got 1", $time);
      value_errors++;
    end

  stall_bubble: assert property (@(negedge clk_i) disable iff (rst_i)
      ram_stall_i |=> !ex_mem_o.valid)
    else begin
      $display("CHECK FAILED t=%0t ex_mem_o.valid expected 0 got 1", $time);
      value_errors++;
    end

  initial begin : stimulus
    id_ex_t ins;
    logic   stall;
    int     tries;
    lfsr_state     = 32'h0361_fc5f;
    value_errors   = 0;
    timeout_errors = 0;
    exp_prev       = '0;
    exp_branches   = 0;
    exp_misses     = 0;
    rst_i          = 1'b1;
    id_ex_i        = '0;
    ram_stall_i    = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_val("ex_mem_o.valid", 32'd0, 32'(ex_mem_o.valid));
    check_val("redirect_o.valid", 32'd0, 32'(redirect_o.valid));
    check_val("bpu_upd_o.valid", 32'd0, 32'(bpu_upd_o.valid));
    check_val("branch_cnt_o", 32'd0, branch_cnt_o);
    check_val("mispredict_cnt_o", 32'd0, mispredict_cnt_o);

    for (int i = 0; i < 40; i++)
      run_cycle(make_instr(alu_classes[rand_bits(2)]), 1'b0);
    wait_drain();

    for (int i = 0; i < 60; i++)
      run_cycle(make_instr(jump_classes[rand_bits(2)]), 1'b0);
    wait_drain();

    // branch held under stall and then accepted
    for (int i = 0; i < 6; i++) begin
      ins = make_instr(EXC_BRANCH);
      repeat (3) run_cycle(ins, 1'b1);
      run_cycle(ins, 1'b0);
    end
    wait_drain();

    for (int i = 0; i < 8; i++)
      run_cycle(make_instr(EXC_EBREAK), 1'b0);
    wait_drain();

    // mixed traffic where upstream repeats an instruction until it advances
    for (int i = 0; i < 80; i++) begin
      ins   = make_instr(mix_classes[rand_bits(4) % 10]);
      stall = 1'b1;
      tries = 0;
      while (stall && tries < STALL_LIMIT) begin
        stall = (rand_bits(2) == 0);
        run_cycle(ins, stall);
        tries++;
      end
      if (stall) begin
        $display("timeout: instruction %0d never advanced after %0d tries", i, tries);
        timeout_errors++;
      end
    end
    wait_drain();

    $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("errors: %0d value, %0d timeout", value_errors, timeout_errors + 1);
    $display("Something failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+src
src/exu_pkg.sv
src/alu.sv
src/branch_resolve.sv
src/exu.sv
src/ex_mem_reg.sv
src/bpu_stats.sv
src/exu_top.sv
verif/exu_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = exu_tb
FILELIST = vlog.f

OBJDIR   = obj_dir
PASS_MSG = Everything OK

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
